// ==== dv/decodeVectors.hex ====
// instr wbRegSel wbData wbEn ctrl fiveExt eightExt elevenExt r1 r2
// ctrl = {illegalOp,immSrc,aluJump,memWrt,brType,regWrt,regDst,regSrc,oper,invA,invB,cin,bSrc,sign}
4153 1 1234 1 2502 fff3 0053 0153 1234 0000
4967 2 beef 1 652a 0007 0067 0167 1234 0000
523a 2 dead 0 a5c2 001a 003a 023a beef 1234
5a55 2 5555 1 e55a 0015 0055 0255 5555 5555
6180 0 0000 0 10505 0000 ff80 0180 1234 0000
7a7f 4 a5a5 1 1c505 ffff 007f 027f 5555 0000
25aa 0 0000 0 80502 000a ffaa fdaa 0000 0000
30f0 7 0f0f 1 8b902 fff0 fff0 00f0 0000 0f0f
2f04 0 0000 0 44504 0004 0004 ff04 0f0f 0000
3cfc 0 0000 0 4f904 fffc fffc fcfc a5a5 0f0f
8382 3 3333 1 20502 0002 ff82 0382 3333 a5a5
8bbf 5 ffff 0 6302 ffff ffbf 03bf 3333 0000
9ac8 0 0000 0 2ed02 0008 ffc8 02c8 5555 0000
919c 0 0000 0 af04 001c 009c 019c 1234 a5a5
c681 6 6666 1 2f04 0001 ff81 fe81 6666 a5a5
ce0c 0 0000 0 7706 000c 000c fe0c 6666 0000
da65 0 0000 0 f528 0005 0065 0265 5555 3333
dce3 7 7777 1 f558 0003 ffe3 fce3 a5a5 7777
d72a 0 0000 0 b480 000a 002a ff2a 7777 1234
f140 0 0000 0 b519 0000 0040 0140 1234 5555
eb80 0 0000 0 7529 0000 ff80 0380 3333 a5a5
1261 5 5a5a 1 108502 0001 0061 0261 5555 3333
1dc0 0 0000 0 10c502 0000 ffc0 fdc0 5a5a 6666
0800 0 0000 0 4502 0000 0000 0000 0000 0000

// ==== decodeStage.f ====
source/isaPkg.sv
source/ctrlPkg.sv
source/controlDecoder.sv
source/selectDecoder.sv
source/regSlice.sv
source/readCombine.sv
source/regFile.sv
source/decodeStage.sv
dv/decodeStageTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= decodeStageTb
RTL_TOP    ?= decodeStage
FILELIST   ?= decodeStage.f
PASS_MSG   := *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== dv/decodeStageTb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the decode stage built with bypassEn set
// Vectors come from dv/decodeVectors.hex with ten hex words per line
// Register state is tracked in a shadow array across all phases
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
module decodeStageTb;
   import isaPkg::*;

   localparam int numVec     = 24;
   localparam int wordsPerV  = 10;
   localparam int numRand    = 200;
   localparam int cycleLimit = 16 + 8 + numVec + numRand + 50;

   logic        clk;
   logic        arstN;
   logic [15:0] instruction;
   logic [2:0]  wbRegSel;
   logic [15:0] wbData;
   logic        wbEn;
   logic        immSrc, aluJump, memWrt, regWrt, invA, invB, cin, sign, illegalOp;
   logic [2:0]  brType;
   logic [2:0]  oper;
   logic [1:0]  regDst;
   logic [1:0]  regSrc;
   logic [1:0]  bSrc;
   logic [15:0] fiveExt, eightExt, elevenExt;
   logic [15:0] r1, r2;

   logic [31:0] vecMem [0:numVec*wordsPerV-1];
   logic [15:0] shadowRegs [0:7];
   logic [15:0] lfsrState;
   int          cycleCount = 0;
   int          ctrlErrs   = 0;
   int          immErrs    = 0;
   int          regErrs    = 0;
   int          checkCount = 0;

   decodeStage #(.bypassEn(1'b1)) DUT (
      .clk(clk), .arstN(arstN), .instruction(instruction),
      .wbRegSel(wbRegSel), .wbData(wbData), .wbEn(wbEn),
      .immSrc(immSrc), .aluJump(aluJump), .memWrt(memWrt), .brType(brType),
      .regWrt(regWrt), .regDst(regDst), .regSrc(regSrc), .oper(oper),
      .invA(invA), .invB(invB), .cin(cin), .bSrc(bSrc), .sign(sign),
      .fiveExt(fiveExt), .eightExt(eightExt), .elevenExt(elevenExt),
      .illegalOp(illegalOp), .r1(r1), .r2(r2)
   );

   // 40 ns clock
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Hard stop on a hung run
   always @(posedge clk) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout: run did not finish within %0d cycles", cycleLimit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////
   // Galois LFSR with taps at 16 14 13 11
   function automatic logic [15:0] nextLfsr(input logic [15:0] s);
      logic fb;
      fb = s[0];
      return (s >> 1) ^ (fb ? 16'hB400 : 16'h0000);
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] randomBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         lfsrState = nextLfsr(lfsrState);
         v = {v[30:0], lfsrState[0]};
      end
      return v;
   endfunction

   // XORI, ANDNI and SLBI take unsigned immediates
   function automatic logic isLogical(input logic [15:0] ins);
      return (ins[15:11] == opXori) || (ins[15:11] == opAndni) || (ins[15:11] == opSlbi);
   endfunction

   function automatic logic [15:0] expFive(input logic [15:0] ins);
      return isLogical(ins) ? {11'd0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
   endfunction

   function automatic logic [15:0] expEight(input logic [15:0] ins);
      return isLogical(ins) ? {8'd0, ins[7:0]} : {{8{ins[7]}}, ins[7:0]};
   endfunction

   function automatic logic [15:0] expEleven(input logic [15:0] ins);
      return {{5{ins[10]}}, ins[10:0]};
   endfunction

   // Shadow read with the same-cycle bypass
   function automatic logic [15:0] modelRead(input logic [2:0] sel);
      return (wbEn && (sel == wbRegSel)) ? wbData : shadowRegs[sel];
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // Checks and phases
   ////////////////////////////////////////////////////////////////////////
   // The kind argument picks the error counter
   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input int kind);
      checkCount++;
      assert (got === exp) else begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         if (kind == 0) ctrlErrs++;
         else if (kind == 1) immErrs++;
         else regErrs++;
      end
   endtask

   task automatic checkImmediates();
      checkValue("fiveExt", 32'(fiveExt), 32'(expFive(instruction)), 1);
      checkValue("eightExt", 32'(eightExt), 32'(expEight(instruction)), 1);
      checkValue("elevenExt", 32'(elevenExt), 32'(expEleven(instruction)), 1);
   endtask

   // SIIC and RTI are reserved and must not write anything
   task automatic checkReserved();
      logic rsvd;
      rsvd = (instruction[15:11] == opSiic) || (instruction[15:11] == opRti);
      checkValue("illegalOp", 32'(illegalOp), 32'(rsvd), 0);
      if (rsvd) begin
         checkCount++;
         assert (!regWrt && !memWrt) else begin
            $display("Reserved opcode %h still enables a register or memory write",
                     instruction[15:11]);
            ctrlErrs++;
         end
      end
   endtask

   task automatic checkReads();
      checkValue("r1", 32'(r1), 32'(modelRead(instruction[10:8])), 2);
      checkValue("r2", 32'(r2), 32'(modelRead(instruction[7:5])), 2);
      // Shadow takes the write at the coming edge
      if (wbEn) shadowRegs[wbRegSel] = wbData;
   endtask

   // Every select reads zero straight out of reset
   task automatic checkReset();
      for (int i = 0; i < 8; i++) begin
         @(posedge clk);
         #2;
         instruction = {5'b11011, 3'(i), 3'(7 - i), 5'd0};
         wbEn        = 1'b0;
         #37;
         checkValue("r1", 32'(r1), 32'd0, 2);
         checkValue("r2", 32'(r2), 32'd0, 2);
      end
   endtask

   task automatic runVector(input int v);
      int          base;
      logic [20:0] ctrlGot;
      base = v * wordsPerV;
      @(posedge clk);
      #2;
      instruction = vecMem[base][15:0];
      wbRegSel    = vecMem[base+1][2:0];
      wbData      = vecMem[base+2][15:0];
      wbEn        = vecMem[base+3][0];
      #37;
      ctrlGot = {illegalOp, immSrc, aluJump, memWrt, brType, regWrt, regDst,
                 regSrc, oper, invA, invB, cin, bSrc, sign};
      checkValue("control", 32'(ctrlGot), vecMem[base+4], 0);
      checkReserved();
      checkValue("fiveExt", 32'(fiveExt), vecMem[base+5], 1);
      checkValue("eightExt", 32'(eightExt), vecMem[base+6], 1);
      checkValue("elevenExt", 32'(elevenExt), vecMem[base+7], 1);
      checkImmediates();
      checkValue("r1", 32'(r1), vecMem[base+8], 2);
      checkValue("r2", 32'(r2), vecMem[base+9], 2);
      checkReads();
   endtask

   task automatic runRandom();
      @(posedge clk);
      #2;
      instruction = 16'(randomBits(16));
      wbRegSel    = 3'(randomBits(3));
      wbData      = 16'(randomBits(16));
      wbEn        = randomBits(1) != 0;
      #37;
      checkReserved();
      checkImmediates();
      checkReads();
   endtask

   initial begin
      arstN       = 1'b0;
      instruction = '0;
      wbRegSel    = '0;
      wbData      = '0;
      wbEn        = 1'b0;
      lfsrState   = 16'd46933;
      for (int i = 0; i < 8; i++) shadowRegs[i] = '0;
      $readmemh("dv/decodeVectors.hex", vecMem);

      repeat (16) @(posedge clk);
      #2;
      arstN = 1'b1;

      checkReset();
      for (int v = 0; v < numVec; v++) runVector(v);
      for (int n = 0; n < numRand; n++) runRandom();

      $display("Checks %0d, errors: control %0d, immediate %0d, register %0d",
               checkCount, ctrlErrs, immErrs, regErrs);
      if (ctrlErrs + immErrs + regErrs == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

// ==== source/decodeStage.sv ====
////////////////////////////////////////////////////////////////////////////
// Decode stage top, control decoder beside the register file
// Control and immediates are combinational from the instruction alone
// Register writes come from writeback and land on the rising edge of clk
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
module decodeStage #(
   parameter bit bypassEn = 1'b1
) (
   input  logic                            clk,
   input  logic                            arstN,
   input  logic [ctrlPkg::dataWidth-1:0]   instruction,
   input  logic [ctrlPkg::regSelWidth-1:0] wbRegSel,
   input  logic [ctrlPkg::dataWidth-1:0]   wbData,
   input  logic                            wbEn,
   output logic                            immSrc,
   output logic                            aluJump,
   output logic                            memWrt,
   output logic [ctrlPkg::brTypeWidth-1:0] brType,
   output logic                            regWrt,
   output logic [ctrlPkg::regDstWidth-1:0] regDst,
   output logic [ctrlPkg::regSrcWidth-1:0] regSrc,
   output logic [ctrlPkg::operWidth-1:0]   oper,
   output logic                            invA,
   output logic                            invB,
   output logic                            cin,
   output logic [ctrlPkg::bSrcWidth-1:0]   bSrc,
   output logic                            sign,
   output logic [ctrlPkg::dataWidth-1:0]   fiveExt,
   output logic [ctrlPkg::dataWidth-1:0]   eightExt,
   output logic [ctrlPkg::dataWidth-1:0]   elevenExt,
   output logic                            illegalOp,
   output logic [ctrlPkg::dataWidth-1:0]   r1,
   output logic [ctrlPkg::dataWidth-1:0]   r2
);
   import isaPkg::*;
   import ctrlPkg::*;

   instrWord               instrView;
   logic [regSelWidth-1:0] rsSel;
   logic [regSelWidth-1:0] rtSel;

   // Read selects are the R-format rs and rt fields
   assign instrView = instruction;
   assign rsSel     = instrView.r.rs;
   assign rtSel     = instrView.r.rt;

   controlDecoder uCtrl (
      .instruction (instrView),
      .immSrc      (immSrc),
      .aluJump     (aluJump),
      .memWrt      (memWrt),
      .brType      (brType),
      .regWrt      (regWrt),
      .regDst      (regDst),
      .regSrc      (regSrc),
      .oper        (oper),
      .invA        (invA),
      .invB        (invB),
      .cin         (cin),
      .bSrc        (bSrc),
      .sign        (sign),
      .fiveExt     (fiveExt),
      .eightExt    (eightExt),
      .elevenExt   (elevenExt),
      .illegalOp   (illegalOp)
   );

   // Writeback drives the write port directly
   regFile #(.bypassEn(bypassEn)) uRegFile (
      .clk    (clk),
      .arstN  (arstN),
      .rd1Sel (rsSel),
      .rd2Sel (rtSel),
      .wrSel  (wbRegSel),
      .wrData (wbData),
      .wrEn   (wbEn),
      .r1     (r1),
      .r2     (r2)
   );

endmodule

// ==== source/regFile.sv ====
////////////////////////////////////////////////////////////////////////////
// Eight-word register file, two combinational reads and one clocked write
// bypassEn is handed unchanged to every slice
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
module regFile #(
   parameter bit bypassEn = 1'b1
) (
   input  logic                            clk,
   input  logic                            arstN,
   input  logic [ctrlPkg::regSelWidth-1:0] rd1Sel,
   input  logic [ctrlPkg::regSelWidth-1:0] rd2Sel,
   input  logic [ctrlPkg::regSelWidth-1:0] wrSel,
   input  logic [ctrlPkg::dataWidth-1:0]   wrData,
   input  logic                            wrEn,
   output logic [ctrlPkg::dataWidth-1:0]   r1,
   output logic [ctrlPkg::dataWidth-1:0]   r2
);
   import ctrlPkg::*;

   logic [numRegs-1:0]                wrHot;
   logic [numRegs-1:0]                rd1Hot;
   logic [numRegs-1:0]                rd2Hot;
   logic [numRegs-1:0][dataWidth-1:0] port1Part;
   logic [numRegs-1:0][dataWidth-1:0] port2Part;

   // Fan-out of the selects
   selectDecoder uSelDec (
      .wrSel  (wrSel),
      .rd1Sel (rd1Sel),
      .rd2Sel (rd2Sel),
      .wrEn   (wrEn),
      .wrHot  (wrHot),
      .rd1Hot (rd1Hot),
      .rd2Hot (rd2Hot)
   );

   for (genvar i = 0; i < numRegs; i++) begin : gSlice
      regSlice #(.bypassEn(bypassEn)) uSlice (
         .clk       (clk),
         .arstN     (arstN),
         .wrHit     (wrHot[i]),
         .rd1Hit    (rd1Hot[i]),
         .rd2Hit    (rd2Hot[i]),
         .wrData    (wrData),
         .port1Part (port1Part[i]),
         .port2Part (port2Part[i])
      );
   end

   // Fan-in of the gated slice outputs
   readCombine uCombine (
      .port1Parts (port1Part),
      .port2Parts (port2Part),
      .r1         (r1),
      .r2         (r2)
   );

endmodule

// ==== source/readCombine.sv ====
////////////////////////////////////////////////////////////////////////////
// OR reduction of the per-slice read parts into the two read words
// Correct only while each read select vector is one-hot
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
module readCombine (
   input  logic [ctrlPkg::numRegs-1:0][ctrlPkg::dataWidth-1:0] port1Parts,
   input  logic [ctrlPkg::numRegs-1:0][ctrlPkg::dataWidth-1:0] port2Parts,
   output logic [ctrlPkg::dataWidth-1:0]                       r1,
   output logic [ctrlPkg::dataWidth-1:0]                       r2
);
   import ctrlPkg::*;

   always_comb begin
      r1 = '0;
      r2 = '0;
      // Deselected slices contribute zero
      for (int i = 0; i < numRegs; i++) begin
         r1 = r1 | port1Parts[i];
         r2 = r2 | port2Parts[i];
      end
   end

endmodule

// ==== source/regSlice.sv ====
////////////////////////////////////////////////////////////////////////////
// One register word with its write strobe and two gated read drivers
// A deselected port drives zero so the read combiner can OR all slices
// With bypassEn set, a same-cycle write is seen on the read ports
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
module regSlice #(
   parameter bit bypassEn = 1'b1
) (
   input  logic                          clk,
   input  logic                          arstN,
   input  logic                          wrHit,
   input  logic                          rd1Hit,
   input  logic                          rd2Hit,
   input  logic [ctrlPkg::dataWidth-1:0] wrData,
   output logic [ctrlPkg::dataWidth-1:0] port1Part,
   output logic [ctrlPkg::dataWidth-1:0] port2Part
);
   import ctrlPkg::*;

   logic [dataWidth-1:0] word;
   logic [dataWidth-1:0] readVal;

   // Registers read zero out of reset
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         word <= '0;
      end else if (wrHit) begin
         word <= wrData;
      end
   end

   // Incoming data wins over the stored word during a write
   assign readVal = (bypassEn && wrHit) ? wrData : word;

   assign port1Part = rd1Hit ? readVal : '0;
   assign port2Part = rd2Hit ? readVal : '0;

endmodule

// ==== source/selectDecoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Register select to one-hot decode for one write and two read ports
// Read vectors are always one-hot, the write vector is zero when disabled
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
module selectDecoder (
   input  logic [ctrlPkg::regSelWidth-1:0] wrSel,
   input  logic [ctrlPkg::regSelWidth-1:0] rd1Sel,
   input  logic [ctrlPkg::regSelWidth-1:0] rd2Sel,
   input  logic                            wrEn,
   output logic [ctrlPkg::numRegs-1:0]     wrHot,
   output logic [ctrlPkg::numRegs-1:0]     rd1Hot,
   output logic [ctrlPkg::numRegs-1:0]     rd2Hot
);
   import ctrlPkg::*;

   // Register 0 alone, shifted to the selected slot
   localparam logic [numRegs-1:0] hotZero = {{(numRegs-1){1'b0}}, 1'b1};

   assign rd1Hot = hotZero << rd1Sel;
   assign rd2Hot = hotZero << rd2Sel;

   // No slice sees a write strobe while the writeback is idle
   assign wrHot  = wrEn ? (hotZero << wrSel) : '0;

endmodule

// ==== source/controlDecoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Opcode to control level decoding, purely combinational
// Reserved opcodes raise illegalOp and never write a register or memory
// oper: 000 rol, 001 sll, 010 ror, 011 srl, 100 add, 101 andn, 111 xor
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
module controlDecoder (
   input  isaPkg::instrWord                   instruction,
   output logic                               immSrc,
   output logic                               aluJump,
   output logic                               memWrt,
   output logic [ctrlPkg::brTypeWidth-1:0]    brType,
   output logic                               regWrt,
   output logic [ctrlPkg::regDstWidth-1:0]    regDst,
   output logic [ctrlPkg::regSrcWidth-1:0]    regSrc,
   output logic [ctrlPkg::operWidth-1:0]      oper,
   output logic                               invA,
   output logic                               invB,
   output logic                               cin,
   output logic [ctrlPkg::bSrcWidth-1:0]      bSrc,
   output logic                               sign,
   output logic [ctrlPkg::dataWidth-1:0]      fiveExt,
   output logic [ctrlPkg::dataWidth-1:0]      eightExt,
   output logic [ctrlPkg::dataWidth-1:0]      elevenExt,
   output logic                               illegalOp
);
   import isaPkg::*;
   import ctrlPkg::*;

   logic [opWidth-1:0] opcode;
   logic [1:0]         func;
   // {class, sub-op} before mapping onto oper
   logic [2:0]         aluSel;
   logic               regWrtRaw;
   logic               memWrtRaw;
   logic               zeroExt;

   assign opcode = instruction.r.opcode;
   assign func   = instruction.r.func;

   ////////////////////////////////////////////////////////////////////////
   // Per-opcode routing
   ////////////////////////////////////////////////////////////////////////
   always_comb begin
      // Defaults describe an immediate ALU op writing I-format rd
      immSrc    = 1'b0;
      aluJump   = 1'b0;
      memWrtRaw = 1'b0;
      regWrtRaw = 1'b1;
      regDst    = regDstRd;
      regSrc    = regSrcAlu;
      bSrc      = bSrcImm5;
      aluSel    = 3'b100;
      case (opcode)
         opHalt, opNop, opSiic, opRti: regWrtRaw = 1'b0;
         // J and JAL take the 11-bit displacement off the PC
         opJ: begin
            immSrc    = 1'b1;
            regWrtRaw = 1'b0;
         end
         opJal: begin
            immSrc = 1'b1;
            regDst = regDstR7;
            regSrc = regSrcPcLink;
         end
         // JR and JALR compute Rs plus imm8 in the ALU
         opJr: begin
            aluJump   = 1'b1;
            regWrtRaw = 1'b0;
            bSrc      = bSrcImm8;
         end
         opJalr: begin
            aluJump = 1'b1;
            regDst  = regDstR7;
            regSrc  = regSrcPcLink;
            bSrc    = bSrcImm8;
         end
         opAddi, opSubi, opXori, opAndni: aluSel = {1'b1, opcode[1:0]};
         opRoli, opSlli, opRori, opSrli: aluSel = {1'b0, opcode[1:0]};
         opBeqz, opBnez, opBltz, opBgez: begin
            regWrtRaw = 1'b0;
            bSrc      = bSrcImm8;
         end
         // Address is Rs plus imm5 for all three
         opSt: begin
            memWrtRaw = 1'b1;
            regWrtRaw = 1'b0;
         end
         opLd: regSrc = regSrcMem;
         // STU also writes the updated address back into Rs
         opStu: begin
            memWrtRaw = 1'b1;
            regDst    = regDstImmRd;
         end
         opLbi, opSlbi: begin
            bSrc   = bSrcImm8;
            regSrc = regSrcBDirect;
            regDst = regDstImmRd;
         end
         opBtr: begin
            bSrc   = bSrcBtr;
            regSrc = regSrcBDirect;
            regDst = regDstRtype;
         end
         // Shift group when opcode bit 0 is low, arithmetic when high
         opShift, opAlu: begin
            aluSel = {opcode[0], func};
            bSrc   = bSrcRt;
            regDst = regDstRtype;
         end
         opSeq, opSlt, opSle, opSco: begin
            bSrc   = bSrcRt;
            regDst = regDstRtype;
         end
         default: regWrtRaw = 1'b0;
      endcase
   end

   // Subtract maps to add, the inverters do the rest
   assign oper = aluSel[2] ? (aluSel[1] ? (aluSel[0] ? 3'b101 : 3'b111) : 3'b100)
                           : aluSel;

   ////////////////////////////////////////////////////////////////////////
   // ALU side levels
   ////////////////////////////////////////////////////////////////////////
   // Rs inverted for SUB, SUBI, SEQ and SLT
   assign invA = (opcode == opSubi) | ((opcode == opAlu) & (func == 2'b01)) |
                 (opcode == opSeq) | (opcode == opSlt);
   // Rt or immediate inverted for ANDN, ANDNI and SLE
   assign invB = (opcode == opAndni) | ((opcode == opAlu) & (func == 2'b11)) |
                 (opcode == opSle);
   // Harmless on ANDN, the carry is unused there
   assign cin  = invA | invB;

   // Branch condition in the low two bits, top bit marks a branch
   assign brType = {opcode[4:2] == 3'b011, opcode[1:0]};
   // Signed test for branches and signed compares
   assign sign   = (opcode[4:2] == 3'b011) | (opcode == opSlt) | (opcode == opSle);

   assign illegalOp = rsvdMask[opcode];
   assign regWrt    = regWrtRaw & ~illegalOp;
   assign memWrt    = memWrtRaw & ~illegalOp;

   ////////////////////////////////////////////////////////////////////////
   // Immediate extension
   ////////////////////////////////////////////////////////////////////////
   // Logical immediates zero-extend
   assign zeroExt = (opcode == opXori) | (opcode == opAndni) | (opcode == opSlbi);

   assign fiveExt  = zeroExt ? {{(dataWidth-5){1'b0}}, instruction.i.imm}
                             : {{(dataWidth-5){instruction.i.imm[4]}}, instruction.i.imm};
   assign eightExt = zeroExt ? {{(dataWidth-8){1'b0}}, instruction.j.disp[7:0]}
                             : {{(dataWidth-8){instruction.j.disp[7]}}, instruction.j.disp[7:0]};
   // Displacement is always signed
   assign elevenExt = {{(dataWidth-11){instruction.j.disp[10]}}, instruction.j.disp};

endmodule

// ==== source/ctrlPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Datapath sizes and control output encodings of the decode stage
// Encodings are shared with the execute and writeback stages
////////////////////////////////////////////////////////////////////////////
package ctrlPkg;

   parameter int dataWidth   = 16;
   parameter int numRegs     = 8;
   parameter int regSelWidth = 3;

   // Control field widths
   parameter int regDstWidth = 2;
   parameter int regSrcWidth = 2;
   parameter int bSrcWidth   = 2;
   parameter int operWidth   = 3;
   parameter int brTypeWidth = 3;

   // Destination register select
   // I-format rd in bits 7:5
   parameter logic [regDstWidth-1:0] regDstRd     = 2'b00;
   // Bits 10:8, for LBI, SLBI and STU
   parameter logic [regDstWidth-1:0] regDstImmRd  = 2'b01;
   // R-format rd in bits 4:2
   parameter logic [regDstWidth-1:0] regDstRtype  = 2'b10;
   // Link register for JAL and JALR
   parameter logic [regDstWidth-1:0] regDstR7     = 2'b11;

   // Writeback data source
   parameter logic [regSrcWidth-1:0] regSrcPcLink  = 2'b00;
   parameter logic [regSrcWidth-1:0] regSrcMem     = 2'b01;
   parameter logic [regSrcWidth-1:0] regSrcAlu     = 2'b10;
   parameter logic [regSrcWidth-1:0] regSrcBDirect = 2'b11;

   // ALU B operand source
   parameter logic [bSrcWidth-1:0] bSrcRt   = 2'b00;
   parameter logic [bSrcWidth-1:0] bSrcImm5 = 2'b01;
   parameter logic [bSrcWidth-1:0] bSrcImm8 = 2'b10;
   parameter logic [bSrcWidth-1:0] bSrcBtr  = 2'b11;

endpackage

// ==== source/isaPkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction set of the 16-bit, eight-register teaching core
// The opcode is always bits 15:11 of the instruction word
// SIIC and RTI keep their encodings but are reserved in this decoder
////////////////////////////////////////////////////////////////////////////
package isaPkg;

   parameter int opWidth = 5;

   // Halt, no-op and the two reserved system opcodes
   parameter logic [opWidth-1:0] opHalt  = 5'b00000;
   parameter logic [opWidth-1:0] opNop   = 5'b00001;
   parameter logic [opWidth-1:0] opSiic  = 5'b00010;
   parameter logic [opWidth-1:0] opRti   = 5'b00011;
   // Jumps
   parameter logic [opWidth-1:0] opJ     = 5'b00100;
   parameter logic [opWidth-1:0] opJr    = 5'b00101;
   parameter logic [opWidth-1:0] opJal   = 5'b00110;
   parameter logic [opWidth-1:0] opJalr  = 5'b00111;
   // Immediate ALU operations
   parameter logic [opWidth-1:0] opAddi  = 5'b01000;
   parameter logic [opWidth-1:0] opSubi  = 5'b01001;
   parameter logic [opWidth-1:0] opXori  = 5'b01010;
   parameter logic [opWidth-1:0] opAndni = 5'b01011;
   // Branches on Rs against zero
   parameter logic [opWidth-1:0] opBeqz  = 5'b01100;
   parameter logic [opWidth-1:0] opBnez  = 5'b01101;
   parameter logic [opWidth-1:0] opBltz  = 5'b01110;
   parameter logic [opWidth-1:0] opBgez  = 5'b01111;
   // Memory and byte loads
   parameter logic [opWidth-1:0] opSt    = 5'b10000;
   parameter logic [opWidth-1:0] opLd    = 5'b10001;
   parameter logic [opWidth-1:0] opSlbi  = 5'b10010;
   parameter logic [opWidth-1:0] opStu   = 5'b10011;
   // Immediate shifts and rotates
   parameter logic [opWidth-1:0] opRoli  = 5'b10100;
   parameter logic [opWidth-1:0] opSlli  = 5'b10101;
   parameter logic [opWidth-1:0] opRori  = 5'b10110;
   parameter logic [opWidth-1:0] opSrli  = 5'b10111;
   // Register-register group, function field picks the operation
   parameter logic [opWidth-1:0] opLbi   = 5'b11000;
   parameter logic [opWidth-1:0] opBtr   = 5'b11001;
   parameter logic [opWidth-1:0] opShift = 5'b11010;
   parameter logic [opWidth-1:0] opAlu   = 5'b11011;
   // Comparisons
   parameter logic [opWidth-1:0] opSeq   = 5'b11100;
   parameter logic [opWidth-1:0] opSlt   = 5'b11101;
   parameter logic [opWidth-1:0] opSle   = 5'b11110;
   parameter logic [opWidth-1:0] opSco   = 5'b11111;

   // One bit per opcode value, set where the opcode is reserved
   parameter logic [31:0] rsvdMask = (32'd1 << opSiic) | (32'd1 << opRti);

   // Same 16 bits, read as R, I or J format
   typedef union packed {
      struct packed {
         logic [opWidth-1:0] opcode;
         logic [2:0]         rs;
         logic [2:0]         rt;
         logic [2:0]         rd;
         logic [1:0]         func;
      } r;
      struct packed {
         logic [opWidth-1:0] opcode;
         logic [2:0]         rs;
         logic [2:0]         rd;
         logic [4:0]         imm;
      } i;
      // Low 8 bits of disp double as the 8-bit immediate
      struct packed {
         logic [opWidth-1:0] opcode;
         logic [10:0]        disp;
      } j;
   } instrWord;

endpackage
